// File: Bender.yml
package:
  name: core_frontend

sources:
  - files:
      - hw/frontend_pkg.sv
      - hw/fetch_if.sv
      - hw/core_npc.sv
      - hw/core_fetch.sv
      - hw/inst_decoder.sv
      - hw/multi_channel_fifo.sv
      - hw/core_frontend.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_frontend.sv

// File: files.f
+incdir+verif
hw/frontend_pkg.sv
hw/fetch_if.sv
hw/core_npc.sv
hw/core_fetch.sv
hw/inst_decoder.sv
hw/multi_channel_fifo.sv
hw/core_frontend.sv
verif/tb_frontend.sv

// File: hw/core_fetch.sv
`timescale 1ns/100ps

module core_fetch (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        flush_i,
  input  logic        stall_i,
  input  logic [31:0] pc_i,
  input  logic [1:0]  slot_valid_i,
  output logic        advance_o,
  output logic        imem_req_valid_o,
  output logic [31:0] imem_req_addr_o,
  input  logic        imem_req_ready_i,
  input  logic        imem_resp_valid_i,
  input  logic [63:0] imem_resp_data_i,
  fetch_if.fetch      grp
);

  typedef enum logic [1:0] {
    S_REQ,
    S_WAIT,
    S_HOLD
  } state_e;

  state_e           state_q;
  logic             req_hold_q;
  logic             stale_q;
  logic [31:0]      req_pc_q;
  logic [1:0]       req_mask_q;
  logic [1:0][31:0] inst_q;
  logic             req_fire;

  // Once raised, a request stays up with the same address until taken
  assign imem_req_valid_o = (state_q == S_REQ) && (req_hold_q || (!flush_i && !stall_i));
  assign imem_req_addr_o  = req_hold_q ? req_pc_q : {pc_i[31:3], 3'b000};
  assign req_fire         = imem_req_valid_o && imem_req_ready_i;

  // A stale request already moved past the old PC, so do not advance again
  assign advance_o = req_fire && !stale_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= S_REQ;
      req_hold_q <= 1'b0;
      stale_q    <= 1'b0;
    end else begin
      case (state_q)
        S_REQ: begin
          if (req_hold_q && flush_i) begin
            stale_q <= 1'b1;
          end
          if (req_fire) begin
            state_q    <= S_WAIT;
            req_hold_q <= 1'b0;
          end else if (imem_req_valid_o) begin
            req_hold_q <= 1'b1;
          end
        end
        S_WAIT: begin
          if (imem_resp_valid_i) begin
            stale_q <= 1'b0;
            // Response of a flushed path is dropped here
            state_q <= (stale_q || flush_i) ? S_REQ : S_HOLD;
          end else if (flush_i) begin
            stale_q <= 1'b1;
          end
        end
        S_HOLD: begin
          if (flush_i || grp.ready) begin
            state_q <= S_REQ;
          end
        end
        default: state_q <= S_REQ;
      endcase
    end
  end

  // Tag of the issued request, kept until its group leaves
  always_ff @(posedge clk) begin
    if (imem_req_valid_o && !req_hold_q) begin
      req_pc_q   <= imem_req_addr_o;
      req_mask_q <= slot_valid_i;
    end
    if (state_q == S_WAIT && imem_resp_valid_i) begin
      inst_q <= imem_resp_data_i;
    end
  end

  assign grp.valid      = (state_q == S_HOLD);
  assign grp.pc         = req_pc_q;
  assign grp.slot_valid = req_mask_q;
  assign grp.inst       = inst_q;

endmodule

// File: hw/core_frontend.sv
`timescale 1ns/100ps

module core_frontend #(
  parameter logic [31:0] RESET_PC   = 32'h1C00_0000,
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic                      imem_req_valid_o,
  output logic [31:0]               imem_req_addr_o,
  input  logic                      imem_req_ready_i,
  input  logic                      imem_resp_valid_i,
  input  logic [63:0]               imem_resp_data_i,
  input  logic                      redirect_i,
  input  logic [31:0]               redirect_target_i,
  input  logic                      wait_i,
  input  logic                      int_i,
  output logic [1:0]                issue_valid_o,
  output frontend_pkg::inst_t [1:0] issue_inst_o,
  input  logic [1:0]                issue_num_i
);

  import frontend_pkg::*;

  logic             idle_stall_q;
  logic [31:0]      npc_pc;
  logic [1:0]       npc_mask;
  logic             advance;
  logic             fifo_ready;
  logic [1:0]       dec_valid_q;
  logic [31:0]      dec_pc_q;
  logic [1:0][31:0] dec_inst_q;
  inst_t [1:0]      dec_rec;
  inst_t [1:0]      fifo_wdata;
  logic [1:0]       fifo_wnum;

  fetch_if grp ();

  core_npc #(
    .RESET_PC(RESET_PC)
  ) u_npc (
    .clk              (clk),
    .rst_n            (rst_n),
    .redirect_i       (redirect_i),
    .redirect_target_i(redirect_target_i),
    .advance_i        (advance),
    .pc_o             (npc_pc),
    .slot_valid_o     (npc_mask)
  );

  core_fetch u_fetch (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush_i          (redirect_i),
    .stall_i          (idle_stall_q),
    .pc_i             (npc_pc),
    .slot_valid_i     (npc_mask),
    .advance_o        (advance),
    .imem_req_valid_o (imem_req_valid_o),
    .imem_req_addr_o  (imem_req_addr_o),
    .imem_req_ready_i (imem_req_ready_i),
    .imem_resp_valid_i(imem_resp_valid_i),
    .imem_resp_data_i (imem_resp_data_i),
    .grp              (grp.fetch)
  );

  // Decode stage register moves only when the queue takes its contents
  assign grp.ready = fifo_ready;

  always_ff @(posedge clk) begin
    if (!rst_n || redirect_i) begin
      dec_valid_q <= 2'b00;
    end else if (grp.ready) begin
      dec_valid_q <= grp.valid ? grp.slot_valid : 2'b00;
    end
  end

  always_ff @(posedge clk) begin
    if (grp.ready && grp.valid) begin
      dec_pc_q   <= grp.pc;
      dec_inst_q <= grp.inst;
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_dec
    inst_decoder u_dec (
      .inst_i(dec_inst_q[p]),
      .pc_i  ({dec_pc_q[31:3], 1'(p), 2'b00}),
      .rec_o (dec_rec[p])
    );
  end

  // Lone slot 1 moves down to record 0
  assign fifo_wdata[0] = dec_valid_q[0] ? dec_rec[0] : dec_rec[1];
  assign fifo_wdata[1] = dec_rec[1];
  assign fifo_wnum     = {1'b0, dec_valid_q[0]} + {1'b0, dec_valid_q[1]};

  multi_channel_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i),
    .write_ready_o(fifo_ready),
    .write_num_i  (fifo_wnum),
    .write_data_i (fifo_wdata),
    .read_valid_o (issue_valid_o),
    .read_num_i   (issue_num_i),
    .read_data_o  (issue_inst_o)
  );

  // Interrupt wins over a wait in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_stall_q <= 1'b0;
    end else if (wait_i && !int_i) begin
      idle_stall_q <= 1'b1;
    end else if (int_i) begin
      idle_stall_q <= 1'b0;
    end
  end

endmodule

// File: hw/core_npc.sv
`timescale 1ns/100ps

module core_npc #(
  parameter logic [31:0] RESET_PC = 32'h1C00_0000
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        redirect_i,
  input  logic [31:0] redirect_target_i,
  input  logic        advance_i,
  output logic [31:0] pc_o,
  output logic [1:0]  slot_valid_o
);

  logic [31:0] pc_q;
  logic [1:0]  mask_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q   <= {RESET_PC[31:3], 3'b000};
      mask_q <= 2'b11;
    end else if (redirect_i) begin
      pc_q   <= {redirect_target_i[31:3], 3'b000};
      // Entering at the second word skips slot 0
      mask_q <= redirect_target_i[2] ? 2'b10 : 2'b11;
    end else if (advance_i) begin
      pc_q   <= pc_q + 32'd8;
      mask_q <= 2'b11;
    end
  end

  assign pc_o         = pc_q;
  assign slot_valid_o = mask_q;

endmodule

// File: hw/fetch_if.sv
`timescale 1ns/100ps

interface fetch_if;

  logic            valid;
  logic            ready;
  logic [31:0]     pc;
  logic [1:0]      slot_valid;
  logic [1:0][31:0] inst;

  modport fetch (
    output valid,
    output pc,
    output slot_valid,
    output inst,
    input  ready
  );

  modport decode (
    input  valid,
    input  pc,
    input  slot_valid,
    input  inst,
    output ready
  );

endinterface

// File: hw/frontend_pkg.sv
package frontend_pkg;

  // Instruction class, bits 31..26
  typedef enum logic [2:0] {
    OP_REG3,
    OP_IMM,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH,
    OP_BL,
    OP_IDLE,
    OP_OTHER
  } op_class_t;

  localparam logic [5:0] OPC_REG3   = 6'h00;
  localparam logic [5:0] OPC_IMM    = 6'h0A;
  localparam logic [5:0] OPC_LOAD   = 6'h0B;
  localparam logic [5:0] OPC_STORE  = 6'h0C;
  localparam logic [5:0] OPC_BL     = 6'h15;
  localparam logic [5:0] OPC_BRANCH = 6'h16;
  localparam logic [5:0] OPC_IDLE   = 6'h19;

  typedef enum logic [1:0] {
    R0_NONE,
    R0_RK,
    R0_RD
  } r0_sel_t;

  typedef enum logic {
    R1_NONE,
    R1_RJ
  } r1_sel_t;

  typedef enum logic [1:0] {
    W_NONE,
    W_RD,
    W_LINK
  } w_sel_t;

  typedef struct packed {
    logic [1:0][4:0] r_reg;
    logic [4:0]      w_reg;
  } reg_info_t;

  // Issue record, 76 bits
  typedef struct packed {
    logic [31:0] pc;
    op_class_t   op;
    reg_info_t   reg_info;
    logic [25:0] imm;
  } inst_t;

  function automatic reg_info_t get_register_info(
    input r0_sel_t     r0_sel,
    input r1_sel_t     r1_sel,
    input w_sel_t      w_sel,
    input logic [31:0] inst
  );
    reg_info_t ret;
    ret = '0;
    case (r0_sel)
      R0_RK:   ret.r_reg[0] = inst[14:10];
      R0_RD:   ret.r_reg[0] = inst[4:0];
      default: ret.r_reg[0] = '0;
    endcase
    ret.r_reg[1] = (r1_sel == R1_RJ) ? inst[9:5] : 5'd0;
    case (w_sel)
      W_RD:    ret.w_reg = inst[4:0];
      W_LINK:  ret.w_reg = 5'd1;
      default: ret.w_reg = '0;
    endcase
    return ret;
  endfunction

endpackage

// File: hw/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
  input  logic [31:0]         inst_i,
  input  logic [31:0]         pc_i,
  output frontend_pkg::inst_t rec_o
);

  import frontend_pkg::*;

  op_class_t op;
  r0_sel_t   r0_sel;
  r1_sel_t   r1_sel;
  w_sel_t    w_sel;

  always_comb begin
    case (inst_i[31:26])
      OPC_REG3:   op = OP_REG3;
      OPC_IMM:    op = OP_IMM;
      OPC_LOAD:   op = OP_LOAD;
      OPC_STORE:  op = OP_STORE;
      OPC_BL:     op = OP_BL;
      OPC_BRANCH: op = OP_BRANCH;
      OPC_IDLE:   op = OP_IDLE;
      default:    op = OP_OTHER;
    endcase
  end

  // Register selects per class
  always_comb begin
    r0_sel = R0_NONE;
    r1_sel = R1_NONE;
    w_sel  = W_NONE;
    case (op)
      OP_REG3: begin
        r0_sel = R0_RK;
        r1_sel = R1_RJ;
        w_sel  = W_RD;
      end
      OP_IMM, OP_LOAD: begin
        r1_sel = R1_RJ;
        w_sel  = W_RD;
      end
      OP_STORE, OP_BRANCH: begin
        // Store data and second compare operand sit in rd
        r0_sel = R0_RD;
        r1_sel = R1_RJ;
      end
      OP_BL: begin
        w_sel = W_LINK;
      end
      default: begin
        r0_sel = R0_NONE;
        r1_sel = R1_NONE;
        w_sel  = W_NONE;
      end
    endcase
  end

  always_comb begin
    rec_o          = '0;
    rec_o.pc       = pc_i;
    rec_o.op       = op;
    rec_o.reg_info = get_register_info(r0_sel, r1_sel, w_sel, inst_i);
    rec_o.imm      = inst_i[25:0];
  end

endmodule

// File: hw/multi_channel_fifo.sv
`timescale 1ns/100ps

module multi_channel_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      flush_i,
  output logic                      write_ready_o,
  input  logic [1:0]                write_num_i,
  input  frontend_pkg::inst_t [1:0] write_data_i,
  output logic [1:0]                read_valid_o,
  input  logic [1:0]                read_num_i,
  output frontend_pkg::inst_t [1:0] read_data_o
);

  import frontend_pkg::*;

  localparam int unsigned ADDR_W = $clog2(FIFO_DEPTH);
  localparam int unsigned PTR_W  = ADDR_W + 1;
  localparam int unsigned CNT_W  = PTR_W + 1;

  // Global pointers, bit 0 picks the bank
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [1:0]       wr_num;
  logic [PTR_W-1:0] wr_idx [2];
  logic [PTR_W-1:0] rd_idx [2];
  inst_t            bank_rdata [2];

  assign write_ready_o = count_q <= CNT_W'(2 * FIFO_DEPTH - 2);
  assign wr_num        = write_ready_o ? write_num_i : 2'd0;

  always_comb begin
    for (int k = 0; k < 2; k++) begin
      wr_idx[k] = wr_ptr_q + PTR_W'(k);
      rd_idx[k] = rd_ptr_q + PTR_W'(k);
    end
  end

  // Consecutive entries fall in different banks, so each bank sees one write
  for (genvar b = 0; b < 2; b++) begin : g_bank
    inst_t             mem_q [FIFO_DEPTH];
    logic              we;
    logic [ADDR_W-1:0] waddr;
    logic [ADDR_W-1:0] raddr;
    inst_t             wdata;

    always_comb begin
      we    = 1'b0;
      waddr = wr_idx[0][PTR_W-1:1];
      wdata = write_data_i[0];
      if (wr_num != 2'd0 && wr_idx[0][0] == 1'(b)) begin
        we = 1'b1;
      end else if (wr_num == 2'd2 && wr_idx[1][0] == 1'(b)) begin
        we    = 1'b1;
        waddr = wr_idx[1][PTR_W-1:1];
        wdata = write_data_i[1];
      end
    end

    always_ff @(posedge clk) begin
      if (we) begin
        mem_q[waddr] <= wdata;
      end
    end

    assign raddr         = (rd_idx[0][0] == 1'(b)) ? rd_idx[0][PTR_W-1:1] : rd_idx[1][PTR_W-1:1];
    assign bank_rdata[b] = mem_q[raddr];
  end

  // Oldest entry always lands in slot 0
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      read_data_o[k] = bank_rdata[rd_idx[k][0]];
    end
  end

  assign read_valid_o[0] = count_q != '0;
  assign read_valid_o[1] = count_q > CNT_W'(1);

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(wr_num);
      rd_ptr_q <= rd_ptr_q + PTR_W'(read_num_i);
      count_q  <= count_q + CNT_W'(wr_num) - CNT_W'(read_num_i);
    end
  end

endmodule

// File: verif/frontend_model.svh
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'hc9bb_ee02;
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

logic [31:0] lfsr_q;
logic [31:0] image [256];
inst_t       exp_q [$];
logic [31:0] model_pc;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] val;
  logic        lsb;
  val = '0;
  for (int i = 0; i < n; i++) begin
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ LFSR_TAPS;
    end
    val = {val[30:0], lsb};
  end
  return val;
endfunction

// Seven defined opcodes plus one undefined value for class other
function automatic logic [5:0] pick_opcode(input logic [2:0] sel);
  case (sel)
    3'd0:    return OPC_REG3;
    3'd1:    return OPC_IMM;
    3'd2:    return OPC_LOAD;
    3'd3:    return OPC_STORE;
    3'd4:    return OPC_BL;
    3'd5:    return OPC_BRANCH;
    3'd6:    return OPC_IDLE;
    default: return 6'h3F;
  endcase
endfunction

task automatic fill_image();
  logic [31:0] w;
  logic [31:0] sel;
  for (int i = 0; i < 256; i++) begin
    w        = rand_bits(32);
    sel      = rand_bits(3);
    image[i] = {pick_opcode(sel[2:0]), w[25:0]};
  end
endtask

// Upper address bits fold into the immediate field
function automatic logic [31:0] word_at(input logic [31:0] addr);
  logic [31:0] w;
  w = image[addr[9:2]];
  return {w[31:26], w[25:0] ^ {4'b0, addr[31:10]}};
endfunction

function automatic inst_t ref_decode(input logic [31:0] pc, input logic [31:0] w);
  inst_t r;
  r     = '0;
  r.pc  = pc;
  r.imm = w[25:0];
  case (w[31:26])
    OPC_REG3: begin
      r.op                = OP_REG3;
      r.reg_info.r_reg[0] = w[14:10];
      r.reg_info.r_reg[1] = w[9:5];
      r.reg_info.w_reg    = w[4:0];
    end
    OPC_IMM, OPC_LOAD: begin
      r.op                = (w[31:26] == OPC_IMM) ? OP_IMM : OP_LOAD;
      r.reg_info.r_reg[1] = w[9:5];
      r.reg_info.w_reg    = w[4:0];
    end
    OPC_STORE, OPC_BRANCH: begin
      r.op                = (w[31:26] == OPC_STORE) ? OP_STORE : OP_BRANCH;
      r.reg_info.r_reg[0] = w[4:0];
      r.reg_info.r_reg[1] = w[9:5];
    end
    OPC_BL: begin
      r.op             = OP_BL;
      r.reg_info.w_reg = 5'd1;
    end
    OPC_IDLE: r.op = OP_IDLE;
    default:  r.op = OP_OTHER;
  endcase
  return r;
endfunction

task automatic refill_expected();
  while (exp_q.size() < 4) begin
    exp_q.push_back(ref_decode(model_pc, word_at(model_pc)));
    model_pc = model_pc + 32'd4;
  end
endtask

task automatic restart_model(input logic [31:0] start_pc);
  exp_q.delete();
  model_pc = start_pc;
  refill_expected();
endtask

`endif

// File: verif/tb_frontend.sv
`timescale 1ns/100ps

module tb_frontend;

  import frontend_pkg::*;

  localparam logic [31:0] RESET_PC       = 32'h1C00_0000;
  localparam int unsigned FIFO_DEPTH     = 4;
  localparam int          TIMEOUT_CYCLES = 20000;

  logic             clk;
  logic             rst_n;
  logic             req_valid;
  logic [31:0]      req_addr;
  logic             req_ready;
  logic             resp_valid;
  logic [63:0]      resp_data;
  logic             redirect;
  logic [31:0]      redirect_target;
  logic             idle_wait;
  logic             irq;
  logic [1:0]       issue_valid;
  inst_t [1:0]      issue_inst;
  logic [1:0]       issue_num;

  `include "frontend_model.svh"

  int          errors;
  int          reg_errors;
  int          issued_cnt;
  int          req_cnt;
  int          cycle_cnt;
  int          tests_passed;
  int          tests_failed;
  int          resp_timer;
  int          class_seen [8];
  logic        fire_seen;
  logic [31:0] fire_addr;
  logic [31:0] resp_addr;
  logic        greedy;
  logic        force_ready;
  logic        pend_redirect;
  logic [31:0] pend_target;
  logic        pend_wait;
  logic        pend_int;
  logic        banned_valid;
  logic [31:0] banned_pc;

  core_frontend #(
    .RESET_PC  (RESET_PC),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .imem_req_valid_o (req_valid),
    .imem_req_addr_o  (req_addr),
    .imem_req_ready_i (req_ready),
    .imem_resp_valid_i(resp_valid),
    .imem_resp_data_i (resp_data),
    .redirect_i       (redirect),
    .redirect_target_i(redirect_target),
    .wait_i           (idle_wait),
    .int_i            (irq),
    .issue_valid_o    (issue_valid),
    .issue_inst_o     (issue_inst),
    .issue_num_i      (issue_num)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  task automatic check_record(input inst_t got);
    inst_t exp;
    refill_expected();
    exp = exp_q.pop_front();
    issued_cnt++;
    class_seen[int'(exp.op)]++;
    if (got.pc !== exp.pc) begin
      $display("** Error: issue_inst_o.pc = %h, expected %h", got.pc, exp.pc);
      errors++;
    end
    if (got.op !== exp.op) begin
      $display("** Error: issue_inst_o.op = %h, expected %h (pc %h)", got.op, exp.op, exp.pc);
      errors++;
    end
    if (got.reg_info !== exp.reg_info) begin
      $display("** Error: issue_inst_o.reg_info = %h, expected %h (pc %h)",
               got.reg_info, exp.reg_info, exp.pc);
      errors++;
      reg_errors++;
    end
    if (got.imm !== exp.imm) begin
      $display("** Error: issue_inst_o.imm = %h, expected %h (pc %h)", got.imm, exp.imm, exp.pc);
      errors++;
    end
    if (banned_valid && got.pc == banned_pc) begin
      $display("Word at group base %h was issued although fetch entered at slot 1", got.pc);
      errors++;
    end
  endtask

  // One clock cycle of responder, control inputs and issue side
  task automatic step();
    int nvalid;
    int pick;
    @(posedge clk);
    #1;
    resp_valid = 1'b0;
    if (fire_seen) begin
      resp_addr  = fire_addr;
      resp_timer = 1 + int'(rand_bits(2));
    end
    if (resp_timer != 0) begin
      resp_timer--;
      if (resp_timer == 0) begin
        resp_valid = 1'b1;
        resp_data  = {word_at(resp_addr + 32'd4), word_at(resp_addr)};
      end
    end
    req_ready       = force_ready || (rand_bits(1) != 0);
    redirect        = pend_redirect;
    redirect_target = pend_target;
    idle_wait       = pend_wait;
    irq             = pend_int;
    pend_redirect   = 1'b0;
    pend_wait       = 1'b0;
    pend_int        = 1'b0;
    nvalid = int'(issue_valid[0]) + int'(issue_valid[1]);
    if (redirect) begin
      pick = 0;
    end else if (greedy) begin
      pick = nvalid;
    end else begin
      pick = int'(rand_bits(2)) % (nvalid + 1);
    end
    issue_num = 2'(pick);
    for (int k = 0; k < pick; k++) begin
      check_record(issue_inst[k]);
    end
    if (redirect) begin
      restart_model(redirect_target);
    end
    #1;
    fire_seen = req_valid && req_ready;
    fire_addr = req_addr;
    if (fire_seen) begin
      req_cnt++;
      if (fire_addr[2:0] != 3'b000) begin
        $display("Request address %h is not 8-byte aligned", fire_addr);
        errors++;
      end
    end
  endtask

  task automatic run_steps(input int n);
    repeat (n) step();
  endtask

  task automatic wait_records(input int n);
    int target;
    target = issued_cnt + n;
    while (issued_cnt < target) begin
      step();
    end
  endtask

  task automatic send_redirect(input logic [31:0] target);
    banned_valid  = target[2];
    banned_pc     = {target[31:3], 3'b000};
    pend_redirect = 1'b1;
    pend_target   = target;
    step();
  endtask

  function automatic logic [31:0] random_target(input logic slot1);
    logic [31:0] r;
    r = rand_bits(7);
    return {RESET_PC[31:10], r[6:0], slot1, 2'b00};
  endfunction

  task automatic report_test(input string name, input int err_mark);
    if (errors == err_mark) begin
      tests_passed++;
      $display("Test %-22s ok", name);
    end else begin
      tests_failed++;
      $display("Test %-22s failed with %0d errors", name, errors - err_mark);
    end
  endtask

  initial begin
    int err_mark;
    int req_mark;
    int iss_mark;
    rst_n = 1'b0;
    req_ready = 1'b0;
    resp_valid = 1'b0;
    resp_data = '0;
    redirect = 1'b0;
    redirect_target = '0;
    idle_wait = 1'b0;
    irq = 1'b0;
    issue_num = 2'd0;
    errors = 0;
    reg_errors = 0;
    issued_cnt = 0;
    req_cnt = 0;
    tests_passed = 0;
    tests_failed = 0;
    resp_timer = 0;
    fire_seen = 1'b0;
    fire_addr = '0;
    resp_addr = '0;
    pend_redirect = 1'b0;
    pend_target = '0;
    pend_wait = 1'b0;
    pend_int = 1'b0;
    banned_valid = 1'b0;
    banned_pc = '0;
    for (int i = 0; i < 8; i++) begin
      class_seen[i] = 0;
    end
    lfsr_q = LFSR_SEED;
    fill_image();
    restart_model(RESET_PC);

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset values and an in-order stream from the reset PC
    err_mark = errors;
    greedy = 1'b1;
    force_ready = 1'b1;
    if (req_valid !== 1'b1) begin
      $display("** Error: imem_req_valid_o = %h after reset, expected 1", req_valid);
      errors++;
    end
    if (issue_valid !== 2'b00) begin
      $display("** Error: issue_valid_o = %h after reset, expected 0", issue_valid);
      errors++;
    end
    wait_records(40);
    report_test("reset stream", err_mark);

    err_mark = errors;
    greedy = 1'b0;
    force_ready = 1'b0;
    wait_records(200);
    report_test("random issue and ready", err_mark);

    // Odd rounds redirect again before the first path settles
    err_mark = errors;
    for (int i = 0; i < 4; i++) begin
      run_steps(int'(rand_bits(3)));
      send_redirect(random_target(1'b0));
      if (i % 2 == 1) begin
        run_steps(1 + int'(rand_bits(2)));
        send_redirect(random_target(1'b0));
      end
      wait_records(16);
    end
    report_test("redirect", err_mark);

    err_mark = errors;
    for (int i = 0; i < 4; i++) begin
      run_steps(int'(rand_bits(3)));
      send_redirect(random_target(1'b1));
      wait_records(16);
    end
    banned_valid = 1'b0;
    report_test("redirect to slot 1", err_mark);

    err_mark = errors;
    greedy = 1'b1;
    force_ready = 1'b1;
    pend_wait = 1'b1;
    run_steps(30);
    req_mark = req_cnt;
    iss_mark = issued_cnt;
    run_steps(50);
    if (req_cnt != req_mark) begin
      $display("Fetch issued %0d requests while parked by wait", req_cnt - req_mark);
      errors++;
    end
    if (issued_cnt != iss_mark) begin
      $display("Issue count grew by %0d while parked by wait", issued_cnt - iss_mark);
      errors++;
    end
    if (issue_valid !== 2'b00) begin
      $display("** Error: issue_valid_o = %h with the queue drained, expected 0", issue_valid);
      errors++;
    end
    pend_int = 1'b1;
    step();
    greedy = 1'b0;
    force_ready = 1'b0;
    wait_records(30);
    report_test("wait and interrupt", err_mark);

    err_mark = errors;
    for (int i = 0; i < 8; i++) begin
      if (class_seen[i] == 0) begin
        $display("Instruction class %0d was never issued", i);
        errors++;
      end
    end
    if (reg_errors != 0) begin
      $display("Register fields broke the class rule in %0d records", reg_errors);
      errors++;
    end
    report_test("class rule", err_mark);

    $display("Tests: %0d passed, %0d failed; %0d records checked, %0d errors",
             tests_passed, tests_failed, issued_cnt, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
